//--- design/ddr3_sched_macros.svh
`ifndef DDR3_SCHED_MACROS_SVH
`define DDR3_SCHED_MACROS_SVH

// Device geometry
`define DDR3_BANKS     8
`define DDR3_BANK_BITS 3
`define DDR3_ROW_BITS  14
`define DDR3_COL_BITS  10

// Flat request address, bank in the top bits
`define DDR3_ADDR_BITS (`DDR3_BANK_BITS + `DDR3_ROW_BITS + `DDR3_COL_BITS)

// DDR3 timing in controller clock cycles
`define DDR3_T_RCD  3    // ACT to RD/WR
`define DDR3_T_RP   3    // PRE to ACT
`define DDR3_T_RAS  8    // ACT to PRE
`define DDR3_T_RFC  20   // REF recovery

// Refresh interval
`define DDR3_T_REFI 400

`endif

//--- design/ddr3_sched_pkg.sv
`include "ddr3_sched_macros.svh"

package ddr3_sched_pkg;

  // Commands as seen by the scheduler
  typedef enum logic [2:0] {
    NOP = 3'd0,
    ACT = 3'd1,
    RD  = 3'd2,
    WR  = 3'd3,
    PRE = 3'd4,
    REF = 3'd5
  } ddr3_cmd_e;

  // One request from the front end
  typedef struct packed {
    logic                       write;
    logic [`DDR3_ADDR_BITS-1:0] addr;   // Bank, row, column from the top
  } mem_req_t;

  // Command a bank machine wants issued
  typedef struct packed {
    ddr3_cmd_e                 cmd;
    logic [`DDR3_ROW_BITS-1:0] addr;   // Row for ACT, column for RD/WR
  } bank_cmd_t;

  // DFI command pins, strobes active low
  typedef struct packed {
    logic                       cs_n;
    logic                       ras_n;
    logic                       cas_n;
    logic                       we_n;
    logic [`DDR3_BANK_BITS-1:0] bank;
    logic [`DDR3_ROW_BITS-1:0]  addr;
  } dfi_cmd_t;

endpackage

//--- design/ddr3_req_decode.sv
`include "ddr3_sched_macros.svh"

module ddr3_req_decode (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  ddr3_sched_pkg::mem_req_t    req_i,
  input  logic [`DDR3_BANKS-1:0]      bank_busy_i,
  input  logic                        refresh_pend_i,
  output logic [`DDR3_BANKS-1:0]      bank_load_o,
  output logic                        load_write_o,
  output logic [`DDR3_ROW_BITS-1:0]   load_row_o,
  output logic [`DDR3_COL_BITS-1:0]   load_col_o
);

  localparam logic [`DDR3_BANKS-1:0] BANK_ONE = 1;

  logic [`DDR3_BANK_BITS-1:0] req_bank;
  logic [`DDR3_ROW_BITS-1:0]  req_row;
  logic [`DDR3_COL_BITS-1:0]  req_col;
  logic                       accept;

  // Address split
  assign {req_bank, req_row, req_col} = req_i.addr;

  // A load strobe still in flight counts as busy, busy only rises after it
  assign req_ready_o = !refresh_pend_i
                    && !bank_busy_i[req_bank]
                    && !bank_load_o[req_bank];

  assign accept = req_valid_i && req_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      bank_load_o <= '0;
    end else begin
      bank_load_o <= accept ? (BANK_ONE << req_bank) : '0;   // One cycle strobe
    end
  end

  // Shared fields, only the strobed bank picks them up
  always_ff @(posedge clock) begin
    if (accept) begin
      load_write_o <= req_i.write;
      load_row_o   <= req_row;
      load_col_o   <= req_col;
    end
  end

  // Never hand a new operation to a bank that is still working on one
  assert property (@(posedge clock) disable iff (reset)
    (bank_load_o & bank_busy_i) == '0)
    else $error("load strobe sent to a busy bank");

endmodule

//--- design/ddr3_bank_fsm.sv
`include "ddr3_sched_macros.svh"

module ddr3_bank_fsm (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        load_i,
  input  logic                        load_write_i,
  input  logic [`DDR3_ROW_BITS-1:0]   load_row_i,
  input  logic [`DDR3_COL_BITS-1:0]   load_col_i,
  input  logic                        refresh_pend_i,
  input  logic                        cmd_grant_i,
  output logic                        cmd_req_o,
  output ddr3_sched_pkg::bank_cmd_t   cmd_o,
  output logic                        busy_o,
  output logic                        closed_o
);

  import ddr3_sched_pkg::*;

  localparam int CW = $clog2(`DDR3_T_RAS + 1);

  // Counters are loaded on the grant edge, so one less than the gap
  localparam logic [CW-1:0] RCD_LOAD = CW'(`DDR3_T_RCD - 1);
  localparam logic [CW-1:0] RP_LOAD  = CW'(`DDR3_T_RP - 1);
  localparam logic [CW-1:0] RAS_LOAD = CW'(`DDR3_T_RAS - 1);

  logic                      row_open;
  logic [`DDR3_ROW_BITS-1:0] open_row;

  // Operation waiting for its column command
  logic                      pending;
  logic                      tgt_write;
  logic [`DDR3_ROW_BITS-1:0] tgt_row;
  logic [`DDR3_COL_BITS-1:0] tgt_col;

  logic [CW-1:0]             trcd_cnt;
  logic [CW-1:0]             trp_cnt;
  logic [CW-1:0]             tras_cnt;

  logic                      req_hold;   // Requested last cycle, not granted
  ddr3_cmd_e                 held_cmd;
  ddr3_cmd_e                 next_cmd;
  logic                      next_ok;
  ddr3_cmd_e                 cmd_sel;
  logic [`DDR3_ROW_BITS-1:0] addr_sel;

  // Next step of the sequence, worked out from the open row
  always_comb begin
    next_cmd = NOP;
    next_ok  = 1'b0;
    if (refresh_pend_i) begin
      if (row_open) begin
        next_cmd = PRE;                      // Close the row for refresh
        next_ok  = (tras_cnt == '0);
      end
    end else if (pending) begin
      if (!row_open) begin
        next_cmd = ACT;
        next_ok  = (trp_cnt == '0);
      end else if (open_row == tgt_row) begin
        next_cmd = tgt_write ? WR : RD;      // Row hit
        next_ok  = (trcd_cnt == '0);
      end else begin
        next_cmd = PRE;                      // Row miss
        next_ok  = (tras_cnt == '0);
      end
    end
  end

  // A raised request stays as it is until granted
  assign cmd_req_o = req_hold || next_ok;
  assign cmd_sel   = req_hold ? held_cmd : next_cmd;

  always_comb begin
    case (cmd_sel)
      ACT:     addr_sel = tgt_row;
      RD, WR:  addr_sel = `DDR3_ROW_BITS'(tgt_col);   // A10 low, no auto precharge
      default: addr_sel = '0;                         // Single bank PRE
    endcase
  end

  assign cmd_o    = '{cmd: cmd_sel, addr: addr_sel};
  assign busy_o   = pending;
  assign closed_o = !row_open && (trp_cnt == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      row_open <= 1'b0;
      pending  <= 1'b0;
      req_hold <= 1'b0;
      held_cmd <= NOP;
      trcd_cnt <= '0;
      trp_cnt  <= '0;
      tras_cnt <= '0;
    end else begin
      req_hold <= cmd_req_o && !cmd_grant_i;
      held_cmd <= cmd_sel;

      if (trcd_cnt != '0) trcd_cnt <= trcd_cnt - 1'b1;
      if (trp_cnt != '0)  trp_cnt  <= trp_cnt - 1'b1;
      if (tras_cnt != '0) tras_cnt <= tras_cnt - 1'b1;

      if (load_i) begin
        pending <= 1'b1;
      end

      if (cmd_grant_i) begin
        case (cmd_sel)
          ACT: begin
            row_open <= 1'b1;
            trcd_cnt <= RCD_LOAD;
            tras_cnt <= RAS_LOAD;
          end
          PRE: begin
            row_open <= 1'b0;
            trp_cnt  <= RP_LOAD;
          end
          RD, WR:  pending <= 1'b0;   // Done, busy drops next cycle
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load_i) begin
      tgt_write <= load_write_i;
      tgt_row   <= load_row_i;
      tgt_col   <= load_col_i;
    end
    if (cmd_grant_i && cmd_sel == ACT) begin
      open_row <= tgt_row;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    cmd_req_o && (cmd_sel inside {RD, WR}) |-> row_open)
    else $error("column command requested on a closed bank");

  assert property (@(posedge clock) disable iff (reset)
    cmd_req_o && (cmd_sel == ACT) |-> !row_open)
    else $error("ACT requested while a row is open");

endmodule

//--- design/ddr3_cmd_arb.sv
`include "ddr3_sched_macros.svh"

module ddr3_cmd_arb (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [`DDR3_BANKS-1:0]      cmd_req_i,
  input  ddr3_sched_pkg::bank_cmd_t   cmd_i [`DDR3_BANKS],
  input  logic [`DDR3_BANKS-1:0]      bank_closed_i,
  output logic [`DDR3_BANKS-1:0]      cmd_grant_o,
  output logic                        refresh_pend_o,
  output ddr3_sched_pkg::dfi_cmd_t    dfi_cmd_o
);

  import ddr3_sched_pkg::*;

  localparam int BB     = `DDR3_BANK_BITS;
  localparam int REFI_W = $clog2(`DDR3_T_REFI);
  localparam int RFC_W  = $clog2(`DDR3_T_RFC);

  localparam logic [REFI_W-1:0] REFI_LOAD = REFI_W'(`DDR3_T_REFI - 1);
  localparam logic [RFC_W-1:0]  RFC_LOAD  = RFC_W'(`DDR3_T_RFC - 1);

  logic [BB-1:0]     rr_ptr;      // Highest priority bank
  logic [BB-1:0]     win_idx;
  logic              win_vld;
  logic [REFI_W-1:0] refi_cnt;
  logic [RFC_W-1:0]  rfc_cnt;
  logic              ref_done;    // REF sent, waiting out tRFC
  logic              issue_ref;
  logic              grant_en;

  // Strobe pattern per command, cs_n always asserted
  function automatic dfi_cmd_t encode(ddr3_cmd_e cmd, logic [BB-1:0] bank,
                                      logic [`DDR3_ROW_BITS-1:0] addr);
    dfi_cmd_t d;
    d.cs_n = 1'b0;
    d.bank = bank;
    d.addr = addr;
    case (cmd)
      ACT:     {d.ras_n, d.cas_n, d.we_n} = 3'b011;
      RD:      {d.ras_n, d.cas_n, d.we_n} = 3'b101;
      WR:      {d.ras_n, d.cas_n, d.we_n} = 3'b100;
      PRE:     {d.ras_n, d.cas_n, d.we_n} = 3'b010;
      REF:     {d.ras_n, d.cas_n, d.we_n} = 3'b001;
      default: {d.ras_n, d.cas_n, d.we_n} = 3'b111;
    endcase
    return d;
  endfunction

  // First requester at or after the pointer
  always_comb begin
    logic [BB-1:0] idx;
    win_vld = 1'b0;
    win_idx = rr_ptr;
    for (int i = 0; i < `DDR3_BANKS; i++) begin
      idx = rr_ptr + BB'(i);   // Wraps with the bank count
      if (!win_vld && cmd_req_i[idx]) begin
        win_vld = 1'b1;
        win_idx = idx;
      end
    end
  end

  assign issue_ref = refresh_pend_o && !ref_done && (&bank_closed_i);
  assign grant_en  = !ref_done && !issue_ref;   // REF owns the bus

  always_comb begin
    cmd_grant_o = '0;
    if (grant_en && win_vld) begin
      cmd_grant_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rr_ptr         <= '0;
      refi_cnt       <= REFI_LOAD;
      rfc_cnt        <= '0;
      ref_done       <= 1'b0;
      refresh_pend_o <= 1'b0;
      dfi_cmd_o      <= encode(NOP, '0, '0);
    end else begin
      if (issue_ref) begin
        ref_done <= 1'b1;
        rfc_cnt  <= RFC_LOAD;
      end else if (ref_done) begin
        if (rfc_cnt == '0) begin
          ref_done       <= 1'b0;
          refresh_pend_o <= 1'b0;
        end else begin
          rfc_cnt <= rfc_cnt - 1'b1;
        end
      end

      // Interval timer comes last so a new period is never lost
      if (refi_cnt == '0) begin
        refi_cnt       <= REFI_LOAD;
        refresh_pend_o <= 1'b1;
      end else begin
        refi_cnt <= refi_cnt - 1'b1;
      end

      if (issue_ref) begin
        dfi_cmd_o <= encode(REF, '0, '0);
      end else if (|cmd_grant_o) begin
        dfi_cmd_o <= encode(cmd_i[win_idx].cmd, win_idx, cmd_i[win_idx].addr);
        rr_ptr    <= win_idx + 1'b1;
      end else begin
        dfi_cmd_o <= encode(NOP, '0, '0);
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) $onehot0(cmd_grant_o))
    else $error("more than one bank granted");

endmodule

//--- design/ddr3_sched.sv
`include "ddr3_sched_macros.svh"

module ddr3_sched (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  ddr3_sched_pkg::mem_req_t    req_i,
  output ddr3_sched_pkg::dfi_cmd_t    dfi_cmd_o
);

  import ddr3_sched_pkg::*;

  logic [`DDR3_BANKS-1:0]    bank_load;
  logic [`DDR3_BANKS-1:0]    bank_busy;
  logic [`DDR3_BANKS-1:0]    bank_closed;
  logic [`DDR3_BANKS-1:0]    cmd_req;
  logic [`DDR3_BANKS-1:0]    cmd_grant;
  logic                      load_write;
  logic [`DDR3_ROW_BITS-1:0] load_row;
  logic [`DDR3_COL_BITS-1:0] load_col;
  logic                      refresh_pend;
  bank_cmd_t                 bank_cmd [`DDR3_BANKS];

  ddr3_req_decode u_decode (
    .clock          (clock),
    .reset          (reset),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .bank_busy_i    (bank_busy),
    .refresh_pend_i (refresh_pend),
    .bank_load_o    (bank_load),
    .load_write_o   (load_write),
    .load_row_o     (load_row),
    .load_col_o     (load_col)
  );

  // One machine per bank, load fields shared
  for (genvar g = 0; g < `DDR3_BANKS; g++) begin : g_bank
    ddr3_bank_fsm u_bank (
      .clock          (clock),
      .reset          (reset),
      .load_i         (bank_load[g]),
      .load_write_i   (load_write),
      .load_row_i     (load_row),
      .load_col_i     (load_col),
      .refresh_pend_i (refresh_pend),
      .cmd_grant_i    (cmd_grant[g]),
      .cmd_req_o      (cmd_req[g]),
      .cmd_o          (bank_cmd[g]),
      .busy_o         (bank_busy[g]),
      .closed_o       (bank_closed[g])
    );
  end

  ddr3_cmd_arb u_arb (
    .clock          (clock),
    .reset          (reset),
    .cmd_req_i      (cmd_req),
    .cmd_i          (bank_cmd),
    .bank_closed_i  (bank_closed),
    .cmd_grant_o    (cmd_grant),
    .refresh_pend_o (refresh_pend),
    .dfi_cmd_o      (dfi_cmd_o)
  );

endmodule

//--- verif/ddr3_sched_tb.sv
`include "ddr3_sched_macros.svh"

module ddr3_sched_tb;

  import ddr3_sched_pkg::*;

  typedef logic [`DDR3_BANK_BITS-1:0] bank_t;

  // One request line of the cases file
  typedef struct packed {
    logic                      write;
    bank_t                     bank;
    logic [`DDR3_ROW_BITS-1:0] row;
    logic [`DDR3_COL_BITS-1:0] col;
    logic                      pre;    // Sequence opens with PRE
    logic                      act;
    logic [15:0]               idle;   // Cycles to wait before sending
  } case_t;

  typedef struct packed {
    ddr3_cmd_e                 cmd;
    logic [`DDR3_ROW_BITS-1:0] addr;
    logic [15:0]               idx;    // Case that queued it
  } exp_t;

  logic     clock;
  logic     reset;
  logic     req_valid;
  logic     req_ready;
  mem_req_t req;
  dfi_cmd_t dfi_cmd;

  case_t cases[$];
  string names[$];
  exp_t  exp_q [`DDR3_BANKS][$];   // Expected DFI commands per bank

  logic [`DDR3_BANKS-1:0] row_open;   // As seen on DFI
  int last_act [`DDR3_BANKS];
  int last_pre [`DDR3_BANKS];
  int cycle;
  int limit;
  int mismatch_cnt;
  int timing_cnt;
  int other_cnt;
  int ref_cnt;
  int last_ref;
  int ref_due;
  int outstanding;
  int inflight;
  int max_inflight;

  ddr3_sched i_dut (
    .clock       (clock),
    .reset       (reset),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_i       (req),
    .dfi_cmd_o   (dfi_cmd)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  task automatic read_cases();
    int    fd;
    string tok [7];
    case_t c;
    fd = $fopen("verif/ddr3_sched_cases.txt", "r");
    assert (fd != 0) else begin
      $display("Cannot open verif/ddr3_sched_cases.txt");
      other_cnt++;
    end
    if (fd != 0) begin
      while ($fscanf(fd, "%s %s %s %s %s %s %s", tok[0], tok[1], tok[2], tok[3],
                     tok[4], tok[5], tok[6]) == 7) begin
        if (tok[0].substr(0, 0) != "#") begin
          assert (tok[5] == "C" || tok[5] == "AC" || tok[5] == "PAC") else begin
            $display("Case %s has an unknown sequence %s", tok[0], tok[5]);
            other_cnt++;
          end
          c.write = 1'(tok[1].atoi());
          c.bank  = `DDR3_BANK_BITS'(tok[2].atoi());
          c.row   = `DDR3_ROW_BITS'(tok[3].atohex());
          c.col   = `DDR3_COL_BITS'(tok[4].atohex());
          c.pre   = (tok[5] == "PAC");
          c.act   = (tok[5] != "C");
          c.idle  = 16'(tok[6].atoi());
          cases.push_back(c);
          names.push_back(tok[0]);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic push_expected(bank_t b, ddr3_cmd_e cmd, logic [`DDR3_ROW_BITS-1:0] addr,
                               int idx);
    exp_t e;
    e.cmd  = cmd;
    e.addr = addr;
    e.idx  = 16'(idx);
    if (exp_q[b].size() == 0) begin
      inflight++;
    end
    exp_q[b].push_back(e);
    outstanding++;
    if (inflight > max_inflight) begin
      max_inflight = inflight;
    end
  endtask

  // Holds valid until the transfer edge, then queues what the bank must do
  task automatic send_request(int idx);
    case_t c;
    c = cases[idx];
    req = '{write: c.write, addr: {c.bank, c.row, c.col}};
    req_valid = 1'b1;
    @(negedge clock);
    while (!req_ready) begin
      @(negedge clock);
    end
    @(posedge clock);
    if (c.pre) begin
      push_expected(c.bank, PRE, '0, idx);
    end
    if (c.act) begin
      push_expected(c.bank, ACT, c.row, idx);
    end
    push_expected(c.bank, c.write ? WR : RD, `DDR3_ROW_BITS'(c.col), idx);   // A10 low
    #1;
    req_valid = 1'b0;
  endtask

  task automatic report_gap(string what, bank_t b, int gap, int min_gap);
    $display("Timing violation on bank %0d: %s after %0d cycles, minimum is %0d",
             b, what, gap, min_gap);
    timing_cnt++;
  endtask

  task automatic check_dfi();
    ddr3_cmd_e cmd;
    ddr3_cmd_e exp_cmd;
    bank_t     b;
    exp_t      e;
    logic      ref_pre;
    b = dfi_cmd.bank;
    case ({dfi_cmd.ras_n, dfi_cmd.cas_n, dfi_cmd.we_n})   // DDR3 truth table
      3'b011:  cmd = ACT;
      3'b101:  cmd = RD;
      3'b100:  cmd = WR;
      3'b010:  cmd = PRE;
      3'b001:  cmd = REF;
      default: cmd = NOP;
    endcase
    assert (!dfi_cmd.cs_n && (cmd != NOP || {dfi_cmd.ras_n, dfi_cmd.cas_n, dfi_cmd.we_n} == 3'b111))
    else begin
      $display("Illegal DFI pin state at cycle %0d", cycle);
      other_cnt++;
    end
    assert (cycle <= ref_due + `DDR3_T_RAS + `DDR3_T_RP + 8) else begin
      $display("No REF issued for the interval due at cycle %0d", ref_due);
      other_cnt++;
      ref_due += `DDR3_T_REFI;
    end
    if (cmd == REF) begin
      assert (row_open == '0) else begin
        $display("REF at cycle %0d while rows are open, banks %b", cycle, row_open);
        other_cnt++;
      end
      assert (cycle >= ref_due - 2) else begin
        $display("REF at cycle %0d before the refresh interval ended", cycle);
        other_cnt++;
      end
      row_open = '0;
      last_ref = cycle;
      ref_due += `DDR3_T_REFI;
      ref_cnt++;
    end else if (cmd != NOP) begin
      assert (ref_cnt == 0 || cycle - last_ref > `DDR3_T_RFC) else begin
        $display("%s on bank %0d only %0d cycles after REF", cmd.name(), b, cycle - last_ref);
        timing_cnt++;
      end
      // Refresh closes open rows on its own
      ref_pre = cmd == PRE && row_open[b] && cycle >= ref_due - 2
                && (exp_q[b].size() == 0 || exp_q[b][0].cmd != PRE);
      assert (ref_pre || exp_q[b].size() != 0) else begin
        $display("Unexpected %s on bank %0d at cycle %0d", cmd.name(), b, cycle);
        other_cnt++;
      end
      if (!ref_pre && exp_q[b].size() != 0) begin
        e = exp_q[b].pop_front();
        exp_cmd = e.cmd;
        outstanding--;
        if (exp_q[b].size() == 0) begin
          inflight--;
        end
        assert (exp_cmd == cmd && (cmd == PRE || e.addr == dfi_cmd.addr)) else begin
          $display("MISMATCH %s: expected %s 0x%h, actual %s 0x%h", names[e.idx],
                   exp_cmd.name(), e.addr, cmd.name(), dfi_cmd.addr);
          mismatch_cnt++;
        end
      end
      case (cmd)
        ACT: begin
          assert (cycle - last_pre[b] >= `DDR3_T_RP)
          else report_gap("ACT after PRE", b, cycle - last_pre[b], `DDR3_T_RP);
          row_open[b] = 1'b1;
          last_act[b] = cycle;
        end
        PRE: begin
          assert (cycle - last_act[b] >= `DDR3_T_RAS)
          else report_gap("PRE after ACT", b, cycle - last_act[b], `DDR3_T_RAS);
          row_open[b] = 1'b0;
          last_pre[b] = cycle;
        end
        default: begin   // RD or WR
          assert (row_open[b] && cycle - last_act[b] >= `DDR3_T_RCD)
          else report_gap("column command after ACT", b, cycle - last_act[b], `DDR3_T_RCD);
        end
      endcase
    end
  endtask

  always @(negedge clock) begin
    if (!reset) begin
      check_dfi();
    end
  end

  // Watchdog
  always @(posedge clock) begin
    if (reset) begin
      cycle <= 0;
    end else begin
      cycle <= cycle + 1;
      if (cycle >= limit) begin
        $display("Timeout after %0d cycles, DFI commands still outstanding: %0d",
                 limit, outstanding);
        $display("Errors: %0d mismatch, %0d timing, %0d other",
                 mismatch_cnt, timing_cnt, other_cnt + 1);
        $display("Simulation FAILED");
        $finish;
      end
    end
  end

  initial begin
    reset        = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    row_open     = '0;
    mismatch_cnt = 0;
    timing_cnt   = 0;
    other_cnt    = 0;
    ref_cnt      = 0;
    last_ref     = 0;
    ref_due      = `DDR3_T_REFI;
    outstanding  = 0;
    inflight     = 0;
    max_inflight = 0;
    foreach (last_act[i]) begin
      last_act[i] = -1000;
      last_pre[i] = -1000;
    end
    read_cases();
    limit = cases.size() * (`DDR3_T_RP + `DDR3_T_RAS + `DDR3_T_RCD + 4) + 2 * `DDR3_T_REFI;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < cases.size(); i++) begin
      if (cases[i].idle != 0) begin
        repeat (cases[i].idle) @(posedge clock);
        #1;
      end
      send_request(i);
    end
    while (outstanding != 0) begin
      @(posedge clock);
    end
    repeat (`DDR3_T_RFC) @(posedge clock);   // Catch stray commands
    assert (cases.size() != 0) else begin
      $display("No cases were read");
      other_cnt++;
    end
    assert (ref_cnt != 0) else begin
      $display("No REF appeared during the run");
      other_cnt++;
    end
    assert (max_inflight >= 2) else begin
      $display("Requests to different banks never overlapped");
      other_cnt++;
    end
    $display("Errors: %0d mismatch, %0d timing, %0d other", mismatch_cnt, timing_cnt, other_cnt);
    if (mismatch_cnt + timing_cnt + other_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- verif/ddr3_sched_cases.txt
#name wr bank row_hex col_hex seq(P=PRE,A=ACT,C=RD/WR) idle_cycles_before
rd_closed_b0   0 0 0123 010 AC  0
wr_hit_b0      1 0 0123 024 C   0
rd_miss_b0     0 0 0456 038 PAC 0
wr_closed_b1   1 1 1000 040 AC  0
rd_closed_b2   0 2 2000 05c AC  0
wr_closed_b3   1 3 3000 060 AC  0
rd_hit_b1      0 1 1000 07f C   0
wr_miss_b2     1 2 2abc 080 PAC 0
rd_closed_b7   0 7 3fff 3ff AC  0
wr_hit_b3      1 3 3000 001 C   0
rd_miss_b7     0 7 0000 000 PAC 0
wr_closed_b4   1 4 0a5a 155 AC  0
rd_closed_b5   0 5 1b6b 2aa AC  0
wr_closed_b6   1 6 2c7c 0f0 AC  0
rd_hit_b6      0 6 2c7c 00f C   0
ref_rd_b0      0 0 0456 100 AC  430
ref_wr_b4      1 4 0a5a 101 AC  0
ref_rd_b7      0 7 0000 102 AC  0
ref_hit_b7     1 7 0000 103 C   0
ref_miss_b4    0 4 0001 104 PAC 0

//--- ddr3_sched.f
+incdir+design
design/ddr3_sched_pkg.sv
design/ddr3_req_decode.sv
design/ddr3_bank_fsm.sv
design/ddr3_cmd_arb.sv
design/ddr3_sched.sv
verif/ddr3_sched_tb.sv

//--- Makefile
TOP = ddr3_sched_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f ddr3_sched.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f ddr3_sched.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
